// File: src/bk_pkg.sv
//////////////////////////////////////////////////////////////////////
// Backup RAM engine shared definitions
// Widths, RTC block layout and the sequencer state
//////////////////////////////////////////////////////////////////////

`default_nettype none

package bk_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host disk side

	// Block address presented to the host
	localparam int LBA_W = 32;
	// Low index bits compared against the cartridge RAM mask
	localparam int BLOCK_IDX_W = 8;
	// One buffer word
	localparam int WORD_W = 16;

	//////////////////////////////////////////////////////////////////////
	// RTC block layout

	localparam int RTC_STAMP_W = 32;
	localparam int RTC_SAVED_W = 48;

	// Timestamp low/high, then saved time in three words
	localparam int RTC_WORD_COUNT = 5;

	// Returned for the rest of the RTC block
	localparam logic [WORD_W-1:0] FILL_WORD = '1;

	//////////////////////////////////////////////////////////////////////
	// Sequencer

	typedef enum logic [1:0] {
		BK_IDLE,
		BK_LOAD,
		BK_SAVE
	} bk_state_e;

endpackage

`default_nettype wire

// File: src/bk_request_tracker.sv
//////////////////////////////////////////////////////////////////////
// Backup request tracker
// Follows image mounts and downloads, unsaved cartridge RAM writes,
// and turns user and automatic requests into start strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_request_tracker (
	input  wire        clk_sys,
	input  wire        reset,
	input  wire        cart_download,
	input  wire        img_mounted,
	input  wire        img_readonly,
	input  wire [63:0] img_size,
	input  wire        cart_has_save,
	input  wire        cram_wr,
	input  wire        osd_status,
	input  wire        load_req,
	input  wire        save_req,
	input  wire        autosave_en,
	input  wire        busy,
	output logic       start_load,
	output logic       start_save,
	output logic       sav_pending,
	output logic       sav_supported
);

	logic bk_ena;
	logic new_load;
	logic old_download;
	logic old_load;
	logic old_save;
	logic bk_load;
	logic bk_save;
	logic download_rise;
	logic download_fall;
	logic strobe_ok;

	assign sav_supported = cart_has_save & bk_ena;

	// Load and save conditions, edge detected below
	assign bk_load = load_req | new_load;
	assign bk_save = save_req | (sav_pending & osd_status & autosave_en);

	assign download_rise = ~old_download & cart_download;
	assign download_fall = old_download & ~cart_download;

	// Hold off while a transfer runs or a strobe is already on its way
	assign strobe_ok = bk_ena & ~busy & ~start_load & ~start_save;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_ena       <= 1'b0;
			new_load     <= 1'b0;
			sav_pending  <= 1'b0;
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			start_load   <= 1'b0;
			start_save   <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= bk_load;
			old_save     <= bk_save;

			// New cartridge, backup off until its image shows up
			if (download_rise)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (download_fall && sav_supported)
				new_load <= 1'b1;
			else if (busy)
				new_load <= 1'b0;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (busy)
				sav_pending <= 1'b0;

			// End of download with a sized image loads at once
			start_load <= strobe_ok &
				((~old_load & bk_load) | (download_fall & (|img_size)));
			start_save <= strobe_ok & ~old_save & bk_save;
		end
	end

	// Sequencer ignores strobes while busy, so none may arrive then
	assert property (@(posedge clk_sys) disable iff (reset)
		busy |-> !(start_load || start_save));

endmodule

`default_nettype wire

// File: src/bk_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Backup transfer sequencer
// Runs a load or save one block at a time against the host
// acknowledge and steps the block counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_sequencer (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  start_load,
	input  wire  start_save,
	input  wire  sd_ack,
	input  wire  last_block,
	output logic sd_rd,
	output logic sd_wr,
	output logic busy,
	output logic bk_loading,
	output logic cnt_clear,
	output logic cnt_advance
);

	bk_pkg::bk_state_e state;

	logic prev_ack;
	logic ack_rise;
	logic ack_fall;
	logic start_any;

	assign ack_rise  = ~prev_ack & sd_ack;
	assign ack_fall  = prev_ack & ~sd_ack;
	assign start_any = start_load | start_save;

	assign busy       = (state != bk_pkg::BK_IDLE);
	assign bk_loading = (state == bk_pkg::BK_LOAD);

	// Counter steps on the same edge as the state change
	assign cnt_clear   = ~busy & start_any;
	assign cnt_advance = busy & ack_fall & ~last_block;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= bk_pkg::BK_IDLE;
			prev_ack <= 1'b0;
			sd_rd    <= 1'b0;
			sd_wr    <= 1'b0;
		end else begin
			prev_ack <= sd_ack;

			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (state)
				bk_pkg::BK_IDLE: begin
					// Load wins over save
					if (start_load) begin
						state <= bk_pkg::BK_LOAD;
						sd_rd <= 1'b1;
						sd_wr <= 1'b0;
					end else if (start_save) begin
						state <= bk_pkg::BK_SAVE;
						sd_rd <= 1'b0;
						sd_wr <= 1'b1;
					end
				end

				default: begin
					// Block done once the host drops sd_ack
					if (ack_fall) begin
						if (last_block) begin
							state <= bk_pkg::BK_IDLE;
						end else begin
							sd_rd <= bk_loading;
							sd_wr <= ~bk_loading;
						end
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Request checks

	assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) |-> (state != bk_pkg::BK_IDLE));

endmodule

`default_nettype wire

// File: src/bk_block_counter.sv
//////////////////////////////////////////////////////////////////////
// Backup block counter
// Holds the host block index and tells save RAM, RTC and last
// blocks apart
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_block_counter (
	input  wire                           clk_sys,
	input  wire                           reset,
	input  wire                           cnt_clear,
	input  wire                           cnt_advance,
	input  wire [bk_pkg::BLOCK_IDX_W-1:0] ram_mask_file,
	input  wire                           rtc_inuse,
	output logic [bk_pkg::LBA_W-1:0]      sd_lba,
	output logic                          in_rtc_block,
	output logic                          last_block
);

	logic [bk_pkg::BLOCK_IDX_W-1:0] low_idx;

	assign low_idx = sd_lba[bk_pkg::BLOCK_IDX_W-1:0];

	// One block past the save RAM holds the RTC words
	assign in_rtc_block = (low_idx > ram_mask_file);

	// With RTC the extra block is the last one
	always_comb begin
		if (rtc_inuse)
			last_block = in_rtc_block;
		else
			last_block = (low_idx >= ram_mask_file);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sd_lba <= '0;
		end else if (cnt_clear) begin
			sd_lba <= '0;
		end else if (cnt_advance) begin
			sd_lba <= sd_lba + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/bk_data_path.sv
//////////////////////////////////////////////////////////////////////
// Backup data path
// Steers host buffer writes to cartridge RAM or RTC and picks the
// word handed back to the host
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_data_path #(
	parameter int BUF_ADDR_W = 8
) (
	input  wire [bk_pkg::LBA_W-1:0]                  sd_lba,
	input  wire                                      in_rtc_block,
	input  wire                                      sd_ack,
	input  wire [BUF_ADDR_W-1:0]                     sd_buff_addr,
	input  wire [bk_pkg::WORD_W-1:0]                 sd_buff_dout,
	input  wire                                      sd_buff_wr,
	input  wire [bk_pkg::WORD_W-1:0]                 bk_q,
	input  wire [bk_pkg::RTC_STAMP_W-1:0]            rtc_timestamp,
	input  wire [bk_pkg::RTC_SAVED_W-1:0]            rtc_savedtime,
	output logic [bk_pkg::WORD_W-1:0]                sd_buff_din,
	output logic [bk_pkg::BLOCK_IDX_W+BUF_ADDR_W-1:0] bk_addr,
	output logic [bk_pkg::WORD_W-1:0]                bk_data,
	output logic                                     bk_wr,
	output logic                                     bk_rtc_wr
);

	localparam int RTC_BITS = bk_pkg::RTC_STAMP_W + bk_pkg::RTC_SAVED_W;

	logic [RTC_BITS-1:0] rtc_block;
	logic                buff_write;

	// Word 0 is the low timestamp half, saved time follows low word first
	assign rtc_block = {rtc_savedtime, rtc_timestamp};

	assign buff_write = sd_buff_wr & sd_ack;

	//////////////////////////////////////////////////////////////////////
	// Host to cartridge

	assign bk_addr = {sd_lba[bk_pkg::BLOCK_IDX_W-1:0], sd_buff_addr};
	assign bk_data = sd_buff_dout;

	// Only save RAM blocks reach the cartridge RAM
	assign bk_wr     = buff_write & ~in_rtc_block;
	assign bk_rtc_wr = buff_write & in_rtc_block;

	//////////////////////////////////////////////////////////////////////
	// Cartridge to host

	always_comb begin
		if (!in_rtc_block)
			sd_buff_din = bk_q;
		else if (sd_buff_addr < bk_pkg::RTC_WORD_COUNT)
			sd_buff_din = rtc_block[sd_buff_addr * bk_pkg::WORD_W +: bk_pkg::WORD_W];
		else
			sd_buff_din = bk_pkg::FILL_WORD;
	end

endmodule

`default_nettype wire

// File: src/bk_backup_top.sv
//////////////////////////////////////////////////////////////////////
// Backup RAM save/load engine
// Tracker, sequencer, block counter and data path
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_backup_top #(
	parameter int BUF_ADDR_W = 8
) (
	input  wire                                      clk_sys,
	input  wire                                      reset,
	// Host disk
	output wire [bk_pkg::LBA_W-1:0]                  sd_lba,
	output wire                                      sd_rd,
	output wire                                      sd_wr,
	input  wire                                      sd_ack,
	input  wire [BUF_ADDR_W-1:0]                     sd_buff_addr,
	input  wire [bk_pkg::WORD_W-1:0]                 sd_buff_dout,
	input  wire                                      sd_buff_wr,
	output wire [bk_pkg::WORD_W-1:0]                 sd_buff_din,
	input  wire                                      img_mounted,
	input  wire                                      img_readonly,
	input  wire [63:0]                               img_size,
	// Cartridge
	input  wire                                      cart_download,
	input  wire                                      cart_has_save,
	input  wire [bk_pkg::BLOCK_IDX_W-1:0]            ram_mask_file,
	input  wire                                      rtc_inuse,
	input  wire [bk_pkg::RTC_STAMP_W-1:0]            rtc_timestamp,
	input  wire [bk_pkg::RTC_SAVED_W-1:0]            rtc_savedtime,
	input  wire [bk_pkg::WORD_W-1:0]                 bk_q,
	input  wire                                      cram_wr,
	output wire [bk_pkg::BLOCK_IDX_W+BUF_ADDR_W-1:0] bk_addr,
	output wire [bk_pkg::WORD_W-1:0]                 bk_data,
	output wire                                      bk_wr,
	output wire                                      bk_rtc_wr,
	// User
	input  wire                                      osd_status,
	input  wire                                      load_req,
	input  wire                                      save_req,
	input  wire                                      autosave_en,
	output wire                                      bk_loading,
	output wire                                      sav_pending,
	output wire                                      sav_supported
);

	wire start_load;
	wire start_save;
	wire busy;
	wire cnt_clear;
	wire cnt_advance;
	wire last_block;
	wire in_rtc_block;

	bk_request_tracker bk_request_tracker_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.cart_has_save (cart_has_save),
		.cram_wr       (cram_wr),
		.osd_status    (osd_status),
		.load_req      (load_req),
		.save_req      (save_req),
		.autosave_en   (autosave_en),
		.busy          (busy),
		.start_load    (start_load),
		.start_save    (start_save),
		.sav_pending   (sav_pending),
		.sav_supported (sav_supported)
	);

	bk_sequencer bk_sequencer_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.start_load  (start_load),
		.start_save  (start_save),
		.sd_ack      (sd_ack),
		.last_block  (last_block),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.busy        (busy),
		.bk_loading  (bk_loading),
		.cnt_clear   (cnt_clear),
		.cnt_advance (cnt_advance)
	);

	bk_block_counter bk_block_counter_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cnt_clear     (cnt_clear),
		.cnt_advance   (cnt_advance),
		.ram_mask_file (ram_mask_file),
		.rtc_inuse     (rtc_inuse),
		.sd_lba        (sd_lba),
		.in_rtc_block  (in_rtc_block),
		.last_block    (last_block)
	);

	bk_data_path #(
		.BUF_ADDR_W (BUF_ADDR_W)
	) bk_data_path_inst (
		.sd_lba        (sd_lba),
		.in_rtc_block  (in_rtc_block),
		.sd_ack        (sd_ack),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.bk_q          (bk_q),
		.rtc_timestamp (rtc_timestamp),
		.rtc_savedtime (rtc_savedtime),
		.sd_buff_din   (sd_buff_din),
		.bk_addr       (bk_addr),
		.bk_data       (bk_data),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr)
	);

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	localparam time HALF_PERIOD = 20ns;

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// Held for two rising edges, released on a falling edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: testbench/bk_backup_tb.sv
//////////////////////////////////////////////////////////////////////
// Backup engine testbench
// Host disk and cartridge models, reference words and test sequence
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bk_backup_tb;

	localparam int BUF_ADDR_W = 8;
	localparam int SEED = 32'h03aa_5ef0;
	localparam int WORDS_PER_ACK = 6;
	// About ten transfers of up to 5 blocks at roughly 15 cycles each
	localparam int TIMEOUT_CYCLES = 20000;

	logic clk_sys, reset;
	logic sd_rd, sd_wr, sd_ack, sd_buff_wr;
	logic [31:0] sd_lba;
	logic [BUF_ADDR_W-1:0] sd_buff_addr;
	logic [15:0] sd_buff_dout, sd_buff_din, bk_q, bk_data;
	logic img_mounted, img_readonly, cart_download, cart_has_save;
	logic [63:0] img_size;
	logic [7:0] ram_mask_file;
	logic rtc_inuse, cram_wr, bk_wr, bk_rtc_wr;
	logic [31:0] rtc_timestamp;
	logic [47:0] rtc_savedtime;
	logic [7+BUF_ADDR_W:0] bk_addr;
	logic osd_status, load_req, save_req, autosave_en;
	logic bk_loading, sav_pending, sav_supported;

	int cycles, fail_count, cur_block, rtc_writes, blocks;
	int unsigned seed_val;
	logic in_rtc, write_now;

	tb_clock_gen tb_clock_gen_inst (.clk_sys(clk_sys), .reset(reset));

	bk_backup_top #(.BUF_ADDR_W(BUF_ADDR_W)) bk_backup_top_inst (
		.clk_sys(clk_sys), .reset(reset),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_ack(sd_ack),
		.sd_buff_addr(sd_buff_addr), .sd_buff_dout(sd_buff_dout),
		.sd_buff_wr(sd_buff_wr), .sd_buff_din(sd_buff_din),
		.img_mounted(img_mounted), .img_readonly(img_readonly), .img_size(img_size),
		.cart_download(cart_download), .cart_has_save(cart_has_save),
		.ram_mask_file(ram_mask_file), .rtc_inuse(rtc_inuse),
		.rtc_timestamp(rtc_timestamp), .rtc_savedtime(rtc_savedtime),
		.bk_q(bk_q), .cram_wr(cram_wr), .bk_addr(bk_addr), .bk_data(bk_data),
		.bk_wr(bk_wr), .bk_rtc_wr(bk_rtc_wr),
		.osd_status(osd_status), .load_req(load_req), .save_req(save_req),
		.autosave_en(autosave_en), .bk_loading(bk_loading),
		.sav_pending(sav_pending), .sav_supported(sav_supported)
	);

	//////////////////////////////////////////////////////////////////////
	// Cartridge RAM model and reference values

	function automatic logic [15:0] ram_word(input logic [15:0] addr);
		return {addr[7:0], addr[15:8]} ^ 16'ha55a;
	endfunction

	assign bk_q = ram_word(bk_addr);

	// Word the host should read back from a given block
	function automatic logic [15:0] expected_din(input int block, input int word,
			input logic [7:0] mask, input logic [31:0] stamp, input logic [47:0] saved);
		if (block <= mask)
			return ram_word({block[7:0], word[7:0]});
		case (word)
			0: return stamp[15:0];
			1: return stamp[31:16];
			2: return saved[15:0];
			3: return saved[31:16];
			4: return saved[47:32];
			default: return 16'hffff;
		endcase
	endfunction

	function automatic int expected_blocks(input logic [7:0] mask, input logic rtc);
		return mask + 1 + (rtc ? 1 : 0);
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			fail_count++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("TB FAILED");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host disk model

	// Answers requests until none follows, returns the block count
	task automatic serve_transfer(input logic is_read, output int count);
		int wait_cnt;
		int delay;
		int w;
		logic got;
		logic [31:0] rnd;
		count = 0;
		got = 1'b1;
		while (got) begin
			got = 1'b0;
			wait_cnt = 0;
			while (!got && wait_cnt < 8) begin
				@(posedge clk_sys);
				if (sd_rd || sd_wr)
					got = 1'b1;
				else
					wait_cnt++;
			end
			if (got) begin
				check_value(sd_rd, is_read, "sd_rd");
				check_value(sd_wr, !is_read, "sd_wr");
				check_value(bk_loading, is_read, "bk_loading");
				check_value(sd_lba, count, "sd_lba");
				cur_block = count;
				count++;
				delay = 1 + ($urandom % 4);
				repeat (delay) @(negedge clk_sys);
				for (w = 0; w < WORDS_PER_ACK; w++) begin
					rnd = $urandom;
					sd_ack = 1'b1;
					sd_buff_addr = w;
					sd_buff_wr = is_read;
					sd_buff_dout = rnd[15:0];
					@(negedge clk_sys);
				end
				sd_ack = 1'b0;
				sd_buff_wr = 1'b0;
			end
		end
	endtask

	task automatic expect_no_request(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			check_value(sd_rd || sd_wr, 1'b0, "unexpected request");
		end
	endtask

	task automatic download_cart(input logic readonly, input logic [7:0] mask,
			input logic rtc);
		@(negedge clk_sys);
		ram_mask_file = mask;
		rtc_inuse = rtc;
		img_readonly = readonly;
		img_size = 64'h8000;
		cart_has_save = 1'b1;
		cart_download = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		repeat (3) @(negedge clk_sys);
		cart_download = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Comparison of buffer traffic

	always @(posedge clk_sys) begin
		if (!reset) begin
			in_rtc = (cur_block > ram_mask_file);
			write_now = sd_ack && sd_buff_wr;
			check_value(bk_wr, write_now && !in_rtc, "bk_wr");
			check_value(bk_rtc_wr, write_now && in_rtc, "bk_rtc_wr");
			if (write_now && !in_rtc) begin
				check_value(bk_addr, {cur_block[7:0], sd_buff_addr}, "bk_addr");
				check_value(bk_data, sd_buff_dout, "bk_data");
			end
			if (write_now && in_rtc)
				rtc_writes++;
			if (sd_ack && !sd_buff_wr)
				check_value(sd_buff_din, expected_din(cur_block, sd_buff_addr,
					ram_mask_file, rtc_timestamp, rtc_savedtime), "sd_buff_din");
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still going after %0d clock cycles", cycles);
			$display("TB FAILED");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		seed_val = $urandom(SEED);
		cycles = 0;
		fail_count = 0;
		cur_block = 0;
		rtc_writes = 0;
		sd_ack = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = '0;
		cart_download = 1'b0;
		cart_has_save = 1'b0;
		ram_mask_file = 8'd2;
		rtc_inuse = 1'b0;
		rtc_timestamp = 32'h6543_21ab;
		rtc_savedtime = 48'h0123_4567_89ab;
		cram_wr = 1'b0;
		osd_status = 1'b0;
		load_req = 1'b0;
		save_req = 1'b0;
		autosave_en = 1'b0;
		wait (reset === 1'b0);
		@(negedge clk_sys);

		// Idle after reset, backup still disabled
		check_value({sd_rd, sd_wr, bk_loading, sav_pending}, 4'b0, "outputs after reset");
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		expect_no_request(10);

		download_cart(1'b0, 8'd2, 1'b0);
		serve_transfer(1'b1, blocks);
		check_value(blocks, expected_blocks(8'd2, 1'b0), "auto load blocks");
		check_value(bk_loading, 1'b0, "bk_loading after load");
		check_value(rtc_writes, 0, "RTC writes without RTC");

		// Load with the RTC block on top
		download_cart(1'b0, 8'd3, 1'b1);
		serve_transfer(1'b1, blocks);
		check_value(blocks, expected_blocks(8'd3, 1'b1), "RTC load blocks");
		check_value(rtc_writes, WORDS_PER_ACK, "RTC writes");

		@(negedge clk_sys);
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		serve_transfer(1'b0, blocks);
		check_value(blocks, expected_blocks(8'd3, 1'b1), "manual save blocks");

		@(negedge clk_sys);
		load_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		serve_transfer(1'b1, blocks);
		check_value(blocks, expected_blocks(8'd3, 1'b1), "manual load blocks");

		// Unsaved write, then autosave when the menu opens
		@(negedge clk_sys);
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		check_value(sav_pending, 1'b1, "sav_pending after write");
		expect_no_request(4);
		@(negedge clk_sys);
		osd_status = 1'b1;
		autosave_en = 1'b1;
		serve_transfer(1'b0, blocks);
		check_value(blocks, expected_blocks(8'd3, 1'b1), "autosave blocks");
		check_value(sav_pending, 1'b0, "sav_pending after autosave");
		@(negedge clk_sys);
		osd_status = 1'b0;
		autosave_en = 1'b0;

		// Read-only image leaves backup off
		download_cart(1'b1, 8'd2, 1'b0);
		expect_no_request(10);
		check_value(sav_supported, 1'b0, "sav_supported read-only");
		@(negedge clk_sys);
		load_req = 1'b1;
		save_req = 1'b1;
		@(negedge clk_sys);
		load_req = 1'b0;
		save_req = 1'b0;
		expect_no_request(10);

		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
src/bk_pkg.sv
src/bk_request_tracker.sv
src/bk_sequencer.sv
src/bk_block_counter.sv
src/bk_data_path.sv
src/bk_backup_top.sv
testbench/tb_clock_gen.sv
testbench/bk_backup_tb.sv
